// ==== Makefile ====
# Verilator build and run for the data-memory block.
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_lsu_datamem
RTL_TOP    ?= lsu_datamem
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= No errors
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail, the simulator status alone does not.
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== data_ram.sv ====
// Doubleword RAM with per-byte write enables and a registered read port; DEPTH set by the top.
`timescale 1ns/1ps

module data_ram
  import lsu_pkg::*;
#(
  parameter int DEPTH = 256
) (
  input  logic       i_clk,
  input  logic       i_rst,
  input  addr_t      i_word_index,
  input  byte_mask_t i_byte_en,
  input  xlen_t      i_lane_wdata,
  input  logic       i_rd_en,
  output xlen_t      o_ram_rdata
);

  // Index width, DEPTH is a power of two.
  localparam int IDX_W = $clog2(DEPTH);

  // Storage array, contents are not cleared.
  xlen_t mem [DEPTH];

  // Wrapped doubleword index.
  logic [IDX_W-1:0] idx;

  // Read register.
  xlen_t rdata_q;

  // Upper index bits drop out, so addresses wrap modulo DEPTH.
  assign idx = i_word_index[IDX_W-1:0];

  // Byte-lane writes.
  // Held off while reset is asserted.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (i_byte_en[b]) begin
          mem[idx][b*8 +: 8] <= i_lane_wdata[b*8 +: 8];
        end
      end
    end
  end

  // Registered read.
  // Loaded only on a read strobe, otherwise it keeps the last load.
  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      rdata_q <= '0;
    end else if (i_rd_en) begin
      rdata_q <= mem[idx];
    end
  end

  assign o_ram_rdata = rdata_q;

endmodule

// ==== filelist.f ====
lsu_pkg.sv
store_align.sv
data_ram.sv
load_extend.sv
lsu_datamem.sv
tb_clock.sv
tb_lsu_datamem.sv

// ==== load_extend.sv ====
// Load-side path: captures operation and offset with the read, then extracts and extends the field.
`timescale 1ns/1ps

module load_extend
  import lsu_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_rd_en,
  input  mem_op_t i_mem_op,
  input  lane_t   i_offset,
  input  xlen_t   i_ram_rdata,
  output xlen_t   o_rdata
);

  // Operation and lane of the load now in the RAM read register.
  mem_op_t op_q;
  lane_t   offset_q;

  // Read doubleword moved down so the field starts at bit 0.
  xlen_t       shifted;
  logic [5:0]  bit_shift;

  // Candidate fields.
  logic [7:0]  byte_f;
  logic [15:0] half_f;
  logic [31:0] word_f;

  // Extended result.
  xlen_t       result;

  // Captured on the same edge that loads the RAM read register.
  // Both reset to zero, so the output reads 0 after reset.
  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      op_q     <= OP_LB;
      offset_q <= '0;
    end else if (i_rd_en) begin
      op_q     <= i_mem_op;
      offset_q <= i_offset;
    end
  end

  assign bit_shift = {offset_q, 3'b000};
  assign shifted   = i_ram_rdata >> bit_shift;

  assign byte_f = shifted[7:0];
  assign half_f = shifted[15:0];
  assign word_f = shifted[31:0];

  // Sign or zero extension by the captured operation.
  always_comb begin
    case (op_q)
      OP_LB: begin
        result = {{56{byte_f[7]}}, byte_f};
      end
      OP_LBU: begin
        result = {56'd0, byte_f};
      end
      OP_LH: begin
        result = {{48{half_f[15]}}, half_f};
      end
      OP_LHU: begin
        result = {48'd0, half_f};
      end
      OP_LW: begin
        result = {{32{word_f[31]}}, word_f};
      end
      OP_LWU: begin
        result = {32'd0, word_f};
      end
      // Full doubleword.
      // OP_NONE is never captured, a read needs a real operation.
      default: begin
        result = shifted;
      end
    endcase
  end

  // Stable until the next read edge since both inputs are registers.
  assign o_rdata = result;

endmodule

// ==== lsu_datamem.sv ====
// Data-memory top level: joins store alignment, the byte-enable RAM and load extension.
`timescale 1ns/1ps

module lsu_datamem
  import lsu_pkg::*;
#(
  // Number of doublewords, a power of two.
  parameter int DEPTH = 256
) (
  input  logic    i_clk,
  input  logic    i_rst,
  input  addr_t   i_addr,
  input  xlen_t   i_wdata,
  input  mem_op_t i_mem_op,
  input  logic    i_wr_en,
  output xlen_t   o_rdata
);

  // Store-side decode results.
  byte_mask_t byte_en;
  xlen_t      lane_wdata;
  logic       rd_en;
  addr_t      word_index;
  lane_t      offset;

  // RAM read register out.
  xlen_t      ram_rdata;

  // Decides read or write and lines the data up with its lanes.
  store_align u_store_align (
    .i_addr       (i_addr),
    .i_wdata      (i_wdata),
    .i_mem_op     (i_mem_op),
    .i_wr_en      (i_wr_en),
    .o_byte_en    (byte_en),
    .o_lane_wdata (lane_wdata),
    .o_rd_en      (rd_en),
    .o_word_index (word_index),
    .o_offset     (offset)
  );

  // Storage.
  // Writes land on the edge, reads appear one cycle later.
  data_ram #(
    .DEPTH (DEPTH)
  ) u_data_ram (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_word_index (word_index),
    .i_byte_en    (byte_en),
    .i_lane_wdata (lane_wdata),
    .i_rd_en      (rd_en),
    .o_ram_rdata  (ram_rdata)
  );

  // Field extraction and sign or zero extension.
  load_extend u_load_extend (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rd_en     (rd_en),
    .i_mem_op    (i_mem_op),
    .i_offset    (offset),
    .i_ram_rdata (ram_rdata),
    .o_rdata     (o_rdata)
  );

endmodule

// ==== lsu_pkg.sv ====
// Shared types, operation codes and size helpers for the data-memory block; import where needed.
package lsu_pkg;

  // Data path width and bytes per doubleword.
  localparam int XLEN           = 64;
  localparam int BYTES_PER_WORD = XLEN / 8;

  // Memory operation code from the execute stage.
  // Loads use the full code, stores only use the size.
  typedef enum logic [2:0] {
    OP_LB   = 3'b000,
    OP_LBU  = 3'b001,
    OP_LH   = 3'b010,
    OP_LHU  = 3'b011,
    OP_LW   = 3'b100,
    OP_LWU  = 3'b101,
    OP_LD   = 3'b110,
    OP_NONE = 3'b111
  } mem_op_t;

  typedef logic [XLEN-1:0]           xlen_t;
  typedef logic [63:0]               addr_t;
  typedef logic [BYTES_PER_WORD-1:0] byte_mask_t;
  typedef logic [2:0]                lane_t;

  // Byte lanes covered by an access at lane 0.
  function automatic byte_mask_t op_base_mask(input mem_op_t op);
    case (op)
      OP_LB, OP_LBU: return 8'b0000_0001;
      OP_LH, OP_LHU: return 8'b0000_0011;
      OP_LW, OP_LWU: return 8'b0000_1111;
      OP_LD:         return 8'b1111_1111;
      default:       return 8'b0000_0000;
    endcase
  endfunction

  // Offset bits kept for natural alignment of the access size.
  function automatic lane_t op_align_mask(input mem_op_t op);
    case (op)
      OP_LH, OP_LHU: return 3'b110;
      OP_LW, OP_LWU: return 3'b100;
      OP_LD:         return 3'b000;
      default:       return 3'b111;
    endcase
  endfunction

endpackage

// ==== store_align.sv ====
// Store-side decode: builds byte enables, lane-shifted data and the read strobe for the RAM.
`timescale 1ns/1ps

module store_align
  import lsu_pkg::*;
(
  input  addr_t      i_addr,
  input  xlen_t      i_wdata,
  input  mem_op_t    i_mem_op,
  input  logic       i_wr_en,
  output byte_mask_t o_byte_en,
  output xlen_t      o_lane_wdata,
  output logic       o_rd_en,
  output addr_t      o_word_index,
  output lane_t      o_offset
);

  // Size mask before the lane shift.
  byte_mask_t base_mask;
  // Mask after shifting to the addressed lane.
  byte_mask_t lane_mask;
  // Low address bits and the aligned version of them.
  lane_t      raw_offset;
  lane_t      aligned_offset;
  // Bit shift amount for the write data.
  logic [5:0] bit_shift;
  // Any access other than OP_NONE.
  logic       access;

  always_comb begin
    access     = (i_mem_op != OP_NONE);
    base_mask  = op_base_mask(i_mem_op);
    raw_offset = i_addr[2:0];
    // Clear the offset bits below the access size.
    // A misaligned address falls back to the naturally aligned slot.
    aligned_offset = raw_offset & op_align_mask(i_mem_op);
    bit_shift      = {aligned_offset, 3'b000};
  end

  // Aligned offsets never push the mask past lane 7.
  assign lane_mask = base_mask << aligned_offset;

  // Only a store with a real operation writes.
  assign o_byte_en = (i_wr_en && access) ? lane_mask : '0;

  // Store data moves up to the addressed lane.
  // Bytes pushed into lanes outside the mask are ignored by the RAM.
  assign o_lane_wdata = i_wdata << bit_shift;

  // The strobe level picks read or write.
  assign o_rd_en = !i_wr_en && access;

  // Doubleword index, the RAM wraps it to its depth.
  assign o_word_index = {3'b000, i_addr[63:3]};

  // Offset handed to the load side for extraction.
  assign o_offset = aligned_offset;

endmodule

// ==== tb_clock.sv ====
// Free-running testbench clock; the testbench sets the period in ns.
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 10
) (
  output logic o_clk
);

  // Starts low, so the first rising edge comes after half a period.
  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      o_clk = ~o_clk;
    end
  end

endmodule

// ==== tb_lsu_datamem.sv ====
// Simulation top that checks the data-memory block against a byte model under LFSR stimulus.
`timescale 1ns/1ps

module tb_lsu_datamem
  import lsu_pkg::*;
();

  // A small RAM makes addresses wrap often.
  localparam int DEPTH        = 16;
  localparam int MEM_BYTES    = DEPTH * BYTES_PER_WORD;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 8;

  // Rounds per test group.
  localparam int SIZE_ROUNDS  = 64;
  localparam int EXT_ROUNDS   = 4;
  localparam int ALIGN_ROUNDS = 16;
  localparam int HOLD_ROUNDS  = 4;
  localparam int MIX_CYCLES   = 2000;

  // Total accesses in the run as cycles per round times rounds for each group.
  localparam int TOTAL_TX = DEPTH + 3 * SIZE_ROUNDS + 9 * EXT_ROUNDS + 2 * ALIGN_ROUNDS
                          + 8 * HOLD_ROUNDS + MIX_CYCLES + 2;

  // Galois LFSR with polynomial x^32 + x^31 + x^29 + x + 1.
  localparam logic [31:0] LFSR_SEED = 32'd86;
  localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;

  logic    clk;
  logic    rst;
  addr_t   addr;
  xlen_t   wdata;
  mem_op_t mem_op;
  logic    wr_en;
  xlen_t   rdata;

  logic [31:0] lfsr_state;

  // Reference memory with one entry per byte address.
  logic [7:0] model_mem [MEM_BYTES];

  // Value o_rdata must show and the test that set it.
  xlen_t exp_rdata;
  string exp_name;

  tb_clock #(
    .PERIOD_NS (CLK_PERIOD)
  ) u_clock (
    .o_clk (clk)
  );

  lsu_datamem #(
    .DEPTH (DEPTH)
  ) i_dut (
    .i_clk    (clk),
    .i_rst    (rst),
    .i_addr   (addr),
    .i_wdata  (wdata),
    .i_mem_op (mem_op),
    .i_wr_en  (wr_en),
    .o_rdata  (rdata)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end else begin
      return s >> 1;
    end
  endfunction

  // One LFSR step per bit taken.
  // The first bit ends up in the MSB.
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Any real operation.
  // Code 111 folds onto a doubleword.
  function automatic mem_op_t rand_op();
    logic [2:0] code;
    code = 3'(rand_bits(3));
    if (code == 3'b111) begin
      code = 3'b110;
    end
    return mem_op_t'(code);
  endfunction

  // Access size in bytes.
  function automatic int access_bytes(input mem_op_t op);
    case (op)
      OP_LB, OP_LBU: return 1;
      OP_LH, OP_LHU: return 2;
      OP_LW, OP_LWU: return 4;
      default:       return 8;
    endcase
  endfunction

  // Wraps into the RAM and rounds down to the access size.
  function automatic int byte_base(input addr_t a, input int size);
    int wrapped;
    wrapped = int'(a % 64'(MEM_BYTES));
    return wrapped - (wrapped % size);
  endfunction

  task automatic model_store(input mem_op_t op, input addr_t a, input xlen_t d);
    int size;
    int base;
    size = access_bytes(op);
    base = byte_base(a, size);
    // Low bytes of the store data go to consecutive addresses.
    for (int i = 0; i < size; i++) begin
      model_mem[base + i] = d[i*8 +: 8];
    end
  endtask

  function automatic xlen_t model_load(input mem_op_t op, input addr_t a);
    int    size;
    int    base;
    logic  is_signed;
    xlen_t raw;
    size      = access_bytes(op);
    base      = byte_base(a, size);
    is_signed = (op == OP_LB) || (op == OP_LH) || (op == OP_LW);
    raw       = '0;
    for (int i = 0; i < size; i++) begin
      raw[i*8 +: 8] = model_mem[base + i];
    end
    // Signed narrow loads fill every bit above the field with ones.
    if (is_signed && size < 8 && raw[size*8-1]) begin
      raw = raw | (~64'd0 << (size * 8));
    end
    return raw;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "Run stopped at the first failure.");
  endtask

  task automatic check_rdata(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      fail_run($sformatf("Error: %s expected %016h actual %016h", name, exp, act));
    end
  endtask

  // One cycle checks the last result and drives the next access.
  task automatic step(input string name, input mem_op_t op, input addr_t a,
                      input xlen_t d, input logic we);
    @(negedge clk);
    // Either the load issued one cycle ago or a held value.
    check_rdata(exp_name, exp_rdata, rdata);
    addr   = a;
    wdata  = d;
    mem_op = op;
    wr_en  = we;
    if (op != OP_NONE) begin
      if (we) begin
        model_store(op, a, d);
      end else begin
        exp_rdata = model_load(op, a);
        exp_name  = name;
      end
    end
  endtask

  task automatic do_store(input mem_op_t op, input addr_t a, input xlen_t d);
    step("store", op, a, d, 1'b1);
  endtask

  task automatic do_load(input string name, input mem_op_t op, input addr_t a);
    step(name, op, a, '0, 1'b0);
  endtask

  // No access.
  // With the strobe high it must still write nothing.
  task automatic do_idle(input logic we, input addr_t a);
    step("idle", OP_NONE, a, rand_bits(64), we);
  endtask

  // Watchdog allows 20 cycles per access plus reset.
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + 20 * TOTAL_TX));
    fail_run("Timeout: the test sequence did not complete in the allowed time.");
  end

  initial begin
    addr_t      a;
    addr_t      a2;
    xlen_t      d;
    mem_op_t    op;
    logic [1:0] kind;
    logic       we;

    lfsr_state = LFSR_SEED;
    rst        = 1'b0;
    addr       = '0;
    wdata      = '0;
    mem_op     = OP_NONE;
    wr_en      = 1'b0;
    exp_rdata  = '0;
    exp_name   = "reset";

    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b1;

    // Output is cleared by reset.
    step("reset", OP_NONE, '0, '0, 1'b0);

    // Known contents in every doubleword.
    for (int w = 0; w < DEPTH; w++) begin
      do_store(OP_LD, addr_t'(w * BYTES_PER_WORD), rand_bits(64));
    end

    // Every size at random offsets.
    // The full word shows the untouched lanes.
    for (int n = 0; n < SIZE_ROUNDS; n++) begin
      op = mem_op_t'(3'(n % 7));
      a  = rand_bits(64);
      do_store(op, a, rand_bits(64));
      do_load("size_load", op, a);
      do_load("size_lanes", OP_LD, a);
    end

    // Signed and unsigned loads of the same field with its sign bit forced high.
    for (int n = 0; n < EXT_ROUNDS; n++) begin
      for (int s = 0; s < 3; s++) begin
        op = mem_op_t'(3'(s * 2));
        a  = rand_bits(64);
        d  = rand_bits(64);
        d[(8 << s) - 1] = 1'b1;
        do_store(op, a, d);
        do_load("ext_signed", op, a);
        do_load("ext_unsigned", mem_op_t'(3'(s * 2 + 1)), a);
      end
    end

    // Misaligned store above the RAM size is read back through an alias.
    for (int n = 0; n < ALIGN_ROUNDS; n++) begin
      op   = mem_op_t'(3'(n % 7));
      a    = rand_bits(64) | 64'h100;
      a[0] = 1'b1;
      // Same aligned slot a few RAM sizes further on.
      a2      = a + (addr_t'(rand_bits(8)) + 64'd1) * addr_t'(MEM_BYTES);
      a2[2:0] = a[2:0] ^ (3'(access_bytes(op) - 1) & 3'(rand_bits(3)));
      do_store(op, a, rand_bits(64));
      do_load("align_wrap", op, a2);
    end

    // Held result through idle cycles before the word is read again.
    for (int n = 0; n < HOLD_ROUNDS; n++) begin
      a = rand_bits(64);
      do_load("hold_load", OP_LD, a);
      // Idle reads point elsewhere so a reloaded read register would show.
      repeat (3) do_idle(1'b0, rand_bits(64));
      // Idle writes target the held word that the confirm load reads.
      repeat (3) do_idle(1'b1, a);
      do_load("hold_confirm", OP_LD, a);
    end

    // Random mix where loads are twice as likely as stores or idles.
    for (int n = 0; n < MIX_CYCLES; n++) begin
      kind = 2'(rand_bits(2));
      op   = rand_op();
      a    = rand_bits(64);
      case (kind)
        2'd0: begin
          do_store(op, a, rand_bits(64));
        end
        2'd1, 2'd2: begin
          do_load("random_mix", op, a);
        end
        default: begin
          we = (rand_bits(1) != 64'd0);
          do_idle(we, a);
        end
      endcase
    end

    // Last load still needs its check.
    step("final", OP_NONE, '0, '0, 1'b0);

    $display("No errors");
    $finish;
  end

endmodule
